// File: hw/tpu_data_pkg.sv
package tpu_data_pkg;

    // lanes per 32-bit word, also the array edge
    localparam int ARRAY_DIM = 4;

    typedef logic signed [7:0]  act_t;
    typedef logic signed [31:0] acc_t;

    // lane 0 sits in the low byte
    typedef act_t [ARRAY_DIM-1:0] lane_row_t;

    // one result row, column 0 in the low word
    typedef acc_t [ARRAY_DIM-1:0] acc_row_t;

endpackage

// File: hw/tpu_cfg_pkg.sv
package tpu_cfg_pkg;

    localparam int APB_AW = 12;

    localparam logic [APB_AW-1:0] REG_CTRL   = 12'h000;
    localparam logic [APB_AW-1:0] REG_CONFIG = 12'h004;
    localparam logic [APB_AW-1:0] REG_STATUS = 12'h008;
    localparam logic [APB_AW-1:0] REG_WEIGHT = 12'h00C;
    localparam logic [APB_AW-1:0] UB_BASE    = 12'h400;
    localparam logic [APB_AW-1:0] ACC_BASE   = 12'h800;

    localparam int MAX_KTILES = 4;
    localparam int ROWS_W     = 5;
    localparam int KT_W       = 3;

    // write word, either four int8 lanes or the config fields
    typedef union packed {
        tpu_data_pkg::lane_row_t lanes;
        struct packed {
            logic [31-ROWS_W-KT_W:0] rsvd;
            logic [KT_W-1:0]         k_tiles;
            logic [ROWS_W-1:0]       rows;
        } cfg;
    } cfg_word_u;

endpackage

// File: hw/tpu_apb_regs.sv
`timescale 1ns/1ns

module tpu_apb_regs #(
    parameter int MAX_ROWS = 16
) (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  logic [tpu_cfg_pkg::APB_AW-1:0]                      paddr_i,
    input  logic                                                psel_i,
    input  logic                                                penable_i,
    input  logic                                                pwrite_i,
    input  logic [31:0]                                         pwdata_i,
    output logic [31:0]                                         prdata_o,
    output logic                                                pready_o,
    output logic                                                pslverr_o,
    output logic                                                start_o,
    output logic [tpu_cfg_pkg::ROWS_W-1:0]                      rows_o,
    output logic [tpu_cfg_pkg::KT_W-1:0]                        k_tiles_o,
    input  logic                                                busy_i,
    input  logic                                                done_i,
    output logic                                                ub_we_o,
    output logic [$clog2(MAX_ROWS*tpu_cfg_pkg::MAX_KTILES)-1:0] ub_waddr_o,
    output tpu_data_pkg::lane_row_t                             ub_wdata_o,
    output logic                                                wf_push_o,
    input  logic                                                wf_full_i,
    output tpu_data_pkg::lane_row_t                             wf_data_o,
    output logic                                                acc_rd_en_o,
    output logic [$clog2(MAX_ROWS*tpu_data_pkg::ARRAY_DIM)-1:0] acc_rd_addr_o,
    input  tpu_data_pkg::acc_t                                  acc_rd_data_i
);
    import tpu_data_pkg::*;
    import tpu_cfg_pkg::*;

    localparam int UAW = $clog2(MAX_ROWS * MAX_KTILES);
    localparam int AAW = $clog2(MAX_ROWS * ARRAY_DIM);

    cfg_word_u         wdata_u;
    cfg_word_u         rd_cfg;
    logic [ROWS_W-1:0] rows_q;
    logic [KT_W-1:0]   ktiles_q;
    logic              done_q;
    logic              rd_wait_q;
    logic              access;
    logic              in_ub;
    logic              in_acc;
    logic              win_rd;
    logic              cfg_ok;
    logic              err;
    logic              wr_ok;

    assign wdata_u = pwdata_i;
    assign access  = psel_i & penable_i;
    assign in_ub   = paddr_i[APB_AW-1:APB_AW-2] == UB_BASE[APB_AW-1:APB_AW-2];
    assign in_acc  = paddr_i[APB_AW-1:APB_AW-2] == ACC_BASE[APB_AW-1:APB_AW-2];
    assign win_rd  = (in_ub | in_acc) & ~pwrite_i;
    assign cfg_ok  = wdata_u.cfg.rows != '0 && wdata_u.cfg.rows <= MAX_ROWS &&
                     wdata_u.cfg.k_tiles != '0 && wdata_u.cfg.k_tiles <= MAX_KTILES;

    always_comb begin
        err = 1'b0;
        if (in_ub | in_acc) begin
            err = busy_i;
        end else if (pwrite_i) begin
            case (paddr_i)
                REG_CTRL:   err = pwdata_i[0] & busy_i;
                REG_CONFIG: err = ~cfg_ok;
                REG_WEIGHT: err = wf_full_i;
                default:    err = 1'b0;
            endcase
        end
    end

    // memory windows need one wait state on read
    assign pready_o  = ~(access & win_rd & ~rd_wait_q);
    assign pslverr_o = access & pready_o & err;
    assign wr_ok     = access & pwrite_i & ~err;

    assign start_o       = wr_ok & (paddr_i == REG_CTRL) & pwdata_i[0];
    assign ub_we_o       = wr_ok & in_ub;
    assign ub_waddr_o    = paddr_i[UAW+1:2];
    assign ub_wdata_o    = wdata_u.lanes;
    assign wf_push_o     = wr_ok & (paddr_i == REG_WEIGHT);
    assign wf_data_o     = wdata_u.lanes;
    assign acc_rd_en_o   = access & in_acc & ~pwrite_i & ~rd_wait_q & ~busy_i;
    assign acc_rd_addr_o = paddr_i[AAW+1:2];
    assign rows_o        = rows_q;
    assign k_tiles_o     = ktiles_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rows_q    <= ROWS_W'(1);
            ktiles_q  <= KT_W'(1);
            done_q    <= 1'b0;
            rd_wait_q <= 1'b0;
        end else begin
            rd_wait_q <= access & win_rd & ~rd_wait_q;
            if (wr_ok && paddr_i == REG_CONFIG) begin
                rows_q   <= wdata_u.cfg.rows;
                ktiles_q <= wdata_u.cfg.k_tiles;
            end
            // sticky until the next start
            if (start_o) begin
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_cfg             = '0;
        rd_cfg.cfg.rows    = rows_q;
        rd_cfg.cfg.k_tiles = ktiles_q;
        prdata_o           = '0;
        if (in_acc) begin
            prdata_o = acc_rd_data_i;
        end else if (!in_ub) begin
            // buffer window is write-only and reads back zero
            case (paddr_i)
                REG_CONFIG: prdata_o = rd_cfg;
                REG_STATUS: prdata_o = {30'b0, done_q, busy_i};
                default:    prdata_o = '0;
            endcase
        end
    end

endmodule

// File: hw/unified_buffer.sv
`timescale 1ns/1ns

module unified_buffer #(
    parameter int MAX_ROWS = 16
) (
    input  logic                                                clk_i,
    input  logic                                                we_i,
    input  logic [$clog2(MAX_ROWS*tpu_cfg_pkg::MAX_KTILES)-1:0] waddr_i,
    input  tpu_data_pkg::lane_row_t                             wdata_i,
    input  logic                                                re_i,
    input  logic [$clog2(MAX_ROWS*tpu_cfg_pkg::MAX_KTILES)-1:0] raddr_i,
    output tpu_data_pkg::lane_row_t                             rdata_o
);
    import tpu_data_pkg::*;
    import tpu_cfg_pkg::*;

    // tile k occupies rows k*MAX_ROWS up to k*MAX_ROWS+MAX_ROWS-1
    localparam int DEPTH = MAX_ROWS * MAX_KTILES;

    lane_row_t mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        if (re_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

// File: hw/weight_fifo.sv
`timescale 1ns/1ns

module weight_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    push_i,
    input  tpu_data_pkg::lane_row_t data_i,
    input  logic                    pop_i,
    output tpu_data_pkg::lane_row_t data_o,
    output logic                    valid_o,
    output logic                    full_o
);
    import tpu_data_pkg::*;

    localparam int PW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    lane_row_t     mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          do_push;
    logic          do_pop;

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & valid_o;
    assign valid_o = count_q != '0;
    assign full_o  = count_q == CW'(FIFO_DEPTH);
    // head word is visible without a pop
    assign data_o  = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CW'(do_push) - CW'(do_pop);
        end
    end

endmodule

// File: hw/systolic_array.sv
`timescale 1ns/1ns

module systolic_array (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  logic                                      load_weight_i,
    input  logic [$clog2(tpu_data_pkg::ARRAY_DIM)-1:0] weight_row_idx_i,
    input  tpu_data_pkg::lane_row_t                   weight_row_i,
    input  logic                                      act_valid_i,
    input  tpu_data_pkg::lane_row_t                   act_row_i,
    output logic                                      result_valid_o,
    output tpu_data_pkg::acc_row_t                    result_row_o
);
    import tpu_data_pkg::*;

    // skew, grid depth and deskew add up to this
    localparam int LATENCY = 2 * ARRAY_DIM;

    lane_row_t          w_q [ARRAY_DIM];
    act_t               a_left [ARRAY_DIM];
    act_t               a_q [ARRAY_DIM][ARRAY_DIM-1];
    acc_t               p_q [ARRAY_DIM][ARRAY_DIM];
    logic [LATENCY-1:0] vld_q;

    // weight row k feeds PE row k
    always_ff @(posedge clk_i) begin
        if (load_weight_i) begin
            w_q[weight_row_idx_i] <= weight_row_i;
        end
    end

    // lane i enters i cycles late
    for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_skew
        if (i == 0) begin : g_direct
            assign a_left[i] = act_row_i[i];
        end else begin : g_delay
            act_t sh_q [i];
            always_ff @(posedge clk_i) begin
                sh_q[0] <= act_row_i[i];
                for (int j = 1; j < i; j++) begin
                    sh_q[j] <= sh_q[j-1];
                end
            end
            assign a_left[i] = sh_q[i-1];
        end
    end

    for (genvar k = 0; k < ARRAY_DIM; k++) begin : g_row
        for (genvar n = 0; n < ARRAY_DIM; n++) begin : g_col
            act_t a_in;
            acc_t p_in;
            if (n == 0) begin : g_edge
                assign a_in = a_left[k];
            end else begin : g_pass
                assign a_in = a_q[k][n-1];
            end
            if (k == 0) begin : g_top
                assign p_in = '0;
            end else begin : g_sum
                assign p_in = p_q[k-1][n];
            end
            // partial sum moves down one row per cycle
            always_ff @(posedge clk_i) begin
                p_q[k][n] <= p_in + a_in * w_q[k][n];
            end
            if (n < ARRAY_DIM - 1) begin : g_fwd
                always_ff @(posedge clk_i) begin
                    a_q[k][n] <= a_in;
                end
            end
        end
    end

    // column n leaves the grid n cycles after column 0
    for (genvar n = 0; n < ARRAY_DIM; n++) begin : g_deskew
        acc_t dq_q [ARRAY_DIM-n];
        always_ff @(posedge clk_i) begin
            dq_q[0] <= p_q[ARRAY_DIM-1][n];
            for (int j = 1; j < ARRAY_DIM - n; j++) begin
                dq_q[j] <= dq_q[j-1];
            end
        end
        assign result_row_o[n] = dq_q[ARRAY_DIM-1-n];
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[LATENCY-2:0], act_valid_i};
        end
    end

    assign result_valid_o = vld_q[LATENCY-1];

endmodule

// File: hw/accumulator_mem.sv
`timescale 1ns/1ns

module accumulator_mem #(
    parameter int MAX_ROWS = 16
) (
    input  logic                                                clk_i,
    input  logic                                                wr_en_i,
    input  logic                                                wr_add_i,
    input  logic [$clog2(MAX_ROWS)-1:0]                         wr_row_i,
    input  tpu_data_pkg::acc_row_t                              wr_data_i,
    input  logic                                                rd_en_i,
    input  logic [$clog2(MAX_ROWS*tpu_data_pkg::ARRAY_DIM)-1:0] rd_addr_i,
    output tpu_data_pkg::acc_t                                  rd_data_o
);
    import tpu_data_pkg::*;

    localparam int LW = $clog2(ARRAY_DIM);
    localparam int AW = $clog2(MAX_ROWS * ARRAY_DIM);

    acc_row_t rf_q [MAX_ROWS];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            // later K tiles add onto the stored partial sums
            for (int i = 0; i < ARRAY_DIM; i++) begin
                rf_q[wr_row_i][i] <= wr_add_i ? rf_q[wr_row_i][i] + wr_data_i[i]
                                              : wr_data_i[i];
            end
        end
        if (rd_en_i) begin
            rd_data_o <= rf_q[rd_addr_i[AW-1:LW]][rd_addr_i[LW-1:0]];
        end
    end

endmodule

// File: hw/control_unit.sv
`timescale 1ns/1ns

module control_unit #(
    parameter int MAX_ROWS = 16
) (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  logic                                                start_i,
    input  logic [tpu_cfg_pkg::ROWS_W-1:0]                      rows_i,
    input  logic [tpu_cfg_pkg::KT_W-1:0]                        k_tiles_i,
    output logic                                                busy_o,
    output logic                                                done_o,
    input  logic                                                wf_valid_i,
    output logic                                                wf_pop_o,
    output logic                                                load_weight_o,
    output logic [$clog2(tpu_data_pkg::ARRAY_DIM)-1:0]          weight_row_idx_o,
    output logic                                                ub_re_o,
    output logic [$clog2(MAX_ROWS*tpu_cfg_pkg::MAX_KTILES)-1:0] ub_raddr_o,
    output logic                                                act_valid_o,
    input  logic                                                result_valid_i,
    output logic                                                acc_we_o,
    output logic                                                acc_add_o,
    output logic [$clog2(MAX_ROWS)-1:0]                         acc_row_o
);
    import tpu_data_pkg::*;
    import tpu_cfg_pkg::*;

    localparam int RW  = $clog2(MAX_ROWS);
    localparam int TW  = $clog2(MAX_KTILES);
    localparam int UAW = $clog2(MAX_ROWS * MAX_KTILES);

    enum logic [1:0] {IDLE, LOAD_WEIGHTS, STREAM, DRAIN} state_q;

    logic [TW-1:0]                tile_q;
    logic [TW-1:0]                last_tile_q;
    logic [$clog2(ARRAY_DIM)-1:0] wrow_q;
    logic [RW-1:0]                issue_q;
    logic [RW-1:0]                wr_rows_q;
    logic [RW-1:0]                last_row_q;
    logic                         last_result;

    // FIFO head goes straight into the array on a pop
    assign wf_pop_o         = state_q == LOAD_WEIGHTS && wf_valid_i;
    assign load_weight_o    = wf_pop_o;
    assign weight_row_idx_o = wrow_q;

    assign ub_re_o    = state_q == STREAM;
    assign ub_raddr_o = UAW'(tile_q) * UAW'(MAX_ROWS) + UAW'(issue_q);

    // the accumulator never stalls, so every result is written at once
    assign acc_we_o    = result_valid_i;
    assign acc_add_o   = tile_q != '0;
    assign acc_row_o   = wr_rows_q;
    assign last_result = result_valid_i && wr_rows_q == last_row_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= IDLE;
            busy_o      <= 1'b0;
            done_o      <= 1'b0;
            act_valid_o <= 1'b0;
            tile_q      <= '0;
            last_tile_q <= '0;
            wrow_q      <= '0;
            issue_q     <= '0;
            wr_rows_q   <= '0;
            last_row_q  <= '0;
        end else begin
            done_o      <= 1'b0;
            // buffer data lags the read by one cycle
            act_valid_o <= ub_re_o;
            if (acc_we_o) begin
                wr_rows_q <= wr_rows_q + 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        last_row_q  <= RW'(rows_i - 1'b1);
                        last_tile_q <= TW'(k_tiles_i - 1'b1);
                        tile_q      <= '0;
                        wrow_q      <= '0;
                        busy_o      <= 1'b1;
                        state_q     <= LOAD_WEIGHTS;
                    end
                end
                LOAD_WEIGHTS: begin
                    // waits here as long as the host has not pushed enough rows
                    if (wf_valid_i) begin
                        wrow_q <= wrow_q + 1'b1;
                        if (wrow_q == ARRAY_DIM - 1) begin
                            issue_q   <= '0;
                            wr_rows_q <= '0;
                            state_q   <= STREAM;
                        end
                    end
                end
                STREAM: begin
                    issue_q <= issue_q + 1'b1;
                    if (issue_q == last_row_q) begin
                        state_q <= DRAIN;
                    end
                end
                DRAIN: begin
                    // weights stay put until the last row is written
                    if (last_result) begin
                        if (tile_q == last_tile_q) begin
                            busy_o  <= 1'b0;
                            done_o  <= 1'b1;
                            state_q <= IDLE;
                        end else begin
                            tile_q  <= tile_q + 1'b1;
                            state_q <= LOAD_WEIGHTS;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// File: hw/tpu_top.sv
`timescale 1ns/1ns

module tpu_top #(
    parameter int MAX_ROWS   = 16,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic [tpu_cfg_pkg::APB_AW-1:0] paddr_i,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [31:0]                    pwdata_i,
    output logic [31:0]                    prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    output logic                           done_o
);
    import tpu_data_pkg::*;
    import tpu_cfg_pkg::*;

    localparam int UAW = $clog2(MAX_ROWS * MAX_KTILES);
    localparam int AAW = $clog2(MAX_ROWS * ARRAY_DIM);
    localparam int RW  = $clog2(MAX_ROWS);

    logic                         start;
    logic [ROWS_W-1:0]            rows;
    logic [KT_W-1:0]              k_tiles;
    logic                         busy;
    logic                         ub_we;
    logic [UAW-1:0]               ub_waddr;
    lane_row_t                    ub_wdata;
    logic                         ub_re;
    logic [UAW-1:0]               ub_raddr;
    lane_row_t                    ub_rdata;
    logic                         wf_push;
    logic                         wf_full;
    logic                         wf_valid;
    logic                         wf_pop;
    lane_row_t                    wf_wdata;
    lane_row_t                    wf_rdata;
    logic                         load_weight;
    logic [$clog2(ARRAY_DIM)-1:0] weight_row_idx;
    logic                         act_valid;
    logic                         result_valid;
    acc_row_t                     result_row;
    logic                         acc_we;
    logic                         acc_add;
    logic [RW-1:0]                acc_row;
    logic                         acc_rd_en;
    logic [AAW-1:0]               acc_rd_addr;
    acc_t                         acc_rd_data;

    tpu_apb_regs #(.MAX_ROWS(MAX_ROWS)) regs_i (
        .clk_i, .rst_i, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .start_o(start), .rows_o(rows), .k_tiles_o(k_tiles),
        .busy_i(busy), .done_i(done_o),
        .ub_we_o(ub_we), .ub_waddr_o(ub_waddr), .ub_wdata_o(ub_wdata),
        .wf_push_o(wf_push), .wf_full_i(wf_full), .wf_data_o(wf_wdata),
        .acc_rd_en_o(acc_rd_en), .acc_rd_addr_o(acc_rd_addr), .acc_rd_data_i(acc_rd_data)
    );

    unified_buffer #(.MAX_ROWS(MAX_ROWS)) ub_i (
        .clk_i, .we_i(ub_we), .waddr_i(ub_waddr), .wdata_i(ub_wdata),
        .re_i(ub_re), .raddr_i(ub_raddr), .rdata_o(ub_rdata)
    );

    weight_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) wf_i (
        .clk_i, .rst_i, .push_i(wf_push), .data_i(wf_wdata),
        .pop_i(wf_pop), .data_o(wf_rdata), .valid_o(wf_valid), .full_o(wf_full)
    );

    systolic_array array_i (
        .clk_i, .rst_i,
        .load_weight_i(load_weight), .weight_row_idx_i(weight_row_idx),
        .weight_row_i(wf_rdata), .act_valid_i(act_valid), .act_row_i(ub_rdata),
        .result_valid_o(result_valid), .result_row_o(result_row)
    );

    accumulator_mem #(.MAX_ROWS(MAX_ROWS)) acc_i (
        .clk_i, .wr_en_i(acc_we), .wr_add_i(acc_add), .wr_row_i(acc_row),
        .wr_data_i(result_row), .rd_en_i(acc_rd_en), .rd_addr_i(acc_rd_addr),
        .rd_data_o(acc_rd_data)
    );

    control_unit #(.MAX_ROWS(MAX_ROWS)) ctrl_i (
        .clk_i, .rst_i, .start_i(start), .rows_i(rows), .k_tiles_i(k_tiles),
        .busy_o(busy), .done_o,
        .wf_valid_i(wf_valid), .wf_pop_o(wf_pop),
        .load_weight_o(load_weight), .weight_row_idx_o(weight_row_idx),
        .ub_re_o(ub_re), .ub_raddr_o(ub_raddr), .act_valid_o(act_valid),
        .result_valid_i(result_valid),
        .acc_we_o(acc_we), .acc_add_o(acc_add), .acc_row_o(acc_row)
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

// File: testbench/tb_tpu.sv
`timescale 1ns/1ns

module tb_tpu;
    import tpu_data_pkg::*;
    import tpu_cfg_pkg::*;

    localparam int          MAX_ROWS    = 16;
    localparam int          FIFO_DEPTH  = 16;
    localparam int          K_MAX       = ARRAY_DIM * MAX_KTILES;
    localparam int          READY_LIMIT = 16;
    localparam int          JOB_LIMIT   = 2000;
    localparam logic [31:0] SEED        = 32'h4996_14c3;

    logic              clk;
    logic              rst;
    logic [APB_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic              done;

    // host copies of A (rows x K) and W (K x 4)
    int a_m [MAX_ROWS][K_MAX];
    int w_m [K_MAX][ARRAY_DIM];

    tb_clock #(.PERIOD_NS(4)) clk_gen_i (.clk_o(clk));

    tpu_top #(.MAX_ROWS(MAX_ROWS), .FIFO_DEPTH(FIFO_DEPTH)) dut_i (
        .clk_i(clk), .rst_i(rst), .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
        .pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
        .pslverr_o(pslverr), .done_o(done)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t ns: %s is %0d, expected %0d", $time, name,
                                    $signed(got), $signed(exp)));
        end
    endtask

    // setup phase, access phase, then wait for pready
    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
        int          n;
        logic [31:0] exp_wait;
        // memory window reads wait one cycle, everything else none
        exp_wait = (!wr && addr >= UB_BASE) ? 32'd1 : 32'd0;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (!pready && n >= READY_LIMIT) begin
                stop_on_error("timeout while waiting for pready_o");
            end
        end while (!pready);
        rdata  = prdata;
        slverr = pslverr;
        check_val("pready_o wait states", 32'(n - 1), exp_wait);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check_val("pslverr_o", 32'(err), 32'(exp_err));
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        check_val("pslverr_o", 32'(err), 32'd0);
    endtask

    function automatic logic [31:0] cfg_word(input int rows, input int kt);
        return 32'((kt << ROWS_W) | rows);
    endfunction

    // lane i in byte i
    function automatic logic [31:0] act_word(input int r, input int t);
        logic [31:0] w;
        for (int i = 0; i < ARRAY_DIM; i++) begin
            w[8*i +: 8] = a_m[r][ARRAY_DIM*t + i][7:0];
        end
        return w;
    endfunction

    function automatic logic [31:0] weight_word(input int c);
        logic [31:0] w;
        for (int i = 0; i < ARRAY_DIM; i++) begin
            w[8*i +: 8] = w_m[c][i][7:0];
        end
        return w;
    endfunction

    task automatic fill_random(input int rows, input int kt);
        for (int c = 0; c < ARRAY_DIM * kt; c++) begin
            for (int r = 0; r < rows; r++) begin
                a_m[r][c] = int'($urandom_range(255, 0)) - 128;
            end
            for (int n = 0; n < ARRAY_DIM; n++) begin
                w_m[c][n] = int'($urandom_range(255, 0)) - 128;
            end
        end
    endtask

    // tile t, row r sits at buffer word t*MAX_ROWS + r
    task automatic load_acts(input int rows, input int kt);
        for (int t = 0; t < kt; t++) begin
            for (int r = 0; r < rows; r++) begin
                apb_write(UB_BASE + APB_AW'((t * MAX_ROWS + r) * 4), act_word(r, t), 1'b0);
            end
        end
    endtask

    task automatic push_weights(input int first, input int count);
        for (int c = first; c < first + count; c++) begin
            apb_write(REG_WEIGHT, weight_word(c), 1'b0);
        end
    endtask

    task automatic configure(input int rows, input int kt);
        logic [31:0] rd;
        apb_write(REG_CONFIG, cfg_word(rows, kt), 1'b0);
        apb_read(REG_CONFIG, rd);
        check_val("config", rd, cfg_word(rows, kt));
    endtask

    task automatic start_job();
        logic [31:0] rd;
        apb_write(REG_CTRL, 32'd1, 1'b0);
        apb_read(REG_STATUS, rd);
        // busy set and done cleared by the start
        check_val("status", rd, 32'd1);
    endtask

    task automatic wait_done(input int limit);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = done;
            n++;
            if (!seen && n >= limit) begin
                stop_on_error("timeout while waiting for done_o");
            end
        end
    endtask

    task automatic expect_no_done(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (done) begin
                stop_on_error("done_o pulsed although the weight FIFO was short of rows");
            end
        end
    endtask

    task automatic check_results(input int rows, input int kt);
        logic [31:0] rd;
        int          sum;
        for (int r = 0; r < rows; r++) begin
            for (int n = 0; n < ARRAY_DIM; n++) begin
                sum = 0;
                for (int c = 0; c < ARRAY_DIM * kt; c++) begin
                    sum += a_m[r][c] * w_m[c][n];
                end
                apb_read(ACC_BASE + APB_AW'((ARRAY_DIM * r + n) * 4), rd);
                check_val($sformatf("prdata_o C[%0d][%0d]", r, n), rd, sum);
            end
        end
    endtask

    task automatic finish_job(input int rows, input int kt);
        logic [31:0] rd;
        wait_done(JOB_LIMIT);
        apb_read(REG_STATUS, rd);
        check_val("status", rd, 32'd2);
        check_results(rows, kt);
    endtask

    task automatic run_job(input int rows, input int kt);
        fill_random(rows, kt);
        load_acts(rows, kt);
        push_weights(0, ARRAY_DIM * kt);
        configure(rows, kt);
        start_job();
        finish_job(rows, kt);
    endtask

    initial begin
        int          rows;
        int          kt;
        logic [31:0] rd;
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        void'($urandom(SEED));
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (int j = 0; j < 3; j++) begin
            run_job($urandom_range(MAX_ROWS, 1), 1);
        end
        // later tiles add into the accumulator
        for (kt = 2; kt <= MAX_KTILES; kt++) begin
            run_job($urandom_range(MAX_ROWS, 1), kt);
        end

        // refused configs keep the old one
        configure(5, 2);
        apb_write(REG_CONFIG, cfg_word(0, 1), 1'b1);
        apb_write(REG_CONFIG, cfg_word(3, 5), 1'b1);
        apb_read(REG_CONFIG, rd);
        check_val("config", rd, cfg_word(5, 2));

        // full FIFO, then start and buffer write while busy
        rows = $urandom_range(MAX_ROWS, 1);
        fill_random(rows, MAX_KTILES);
        load_acts(rows, MAX_KTILES);
        push_weights(0, FIFO_DEPTH);
        apb_write(REG_WEIGHT, 32'h7f7f_7f7f, 1'b1);
        configure(rows, MAX_KTILES);
        start_job();
        apb_write(REG_CTRL, 32'd1, 1'b1);
        apb_write(UB_BASE + APB_AW'((MAX_KTILES - 1) * MAX_ROWS * 4),
                  ~act_word(0, MAX_KTILES - 1), 1'b1);
        finish_job(rows, MAX_KTILES);

        // only half a tile of weights at start
        rows = $urandom_range(MAX_ROWS, 1);
        fill_random(rows, 2);
        load_acts(rows, 2);
        push_weights(0, 2);
        configure(rows, 2);
        start_job();
        expect_no_done(200);
        push_weights(2, 2 * ARRAY_DIM - 2);
        finish_job(rows, 2);

        for (int j = 0; j < 6; j++) begin
            run_job($urandom_range(MAX_ROWS, 1), $urandom_range(MAX_KTILES, 1));
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: all.f
hw/tpu_data_pkg.sv
hw/tpu_cfg_pkg.sv
hw/tpu_apb_regs.sv
hw/unified_buffer.sv
hw/weight_fifo.sv
hw/systolic_array.sv
hw/accumulator_mem.sv
hw/control_unit.sv
hw/tpu_top.sv
testbench/tb_clock.sv
testbench/tb_tpu.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_tpu
FILELIST   := all.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
PASS_MSG   := TESTBENCH PASSED
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
